//--- sim.f
+incdir+source
source/video_pkg.sv
source/bus_pkg.sv
source/frame_ifs.sv
source/video_timing.sv
source/ycbcr_to_rgb565.sv
source/mem_arbiter.sv
source/frame_ram.sv
source/frame_top.sv
sim/tb_frame_top.sv

//--- sim/tb_frame_top.sv
//----------------------------------------------------------
// frame grabber testbench: decoder fields, host reads,
// rgb565 reference model and checking assertions
//----------------------------------------------------------
`include "frame_consts.svh"

module tb_frame_top
   import video_pkg::*, bus_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   logic       clk_llc = 1'b0;
   logic       resetx;
   logic       vref;
   logic       href;
   logic       odd;
   logic [7:0] vid_data;
   word_addr_t host_addr;
   logic       host_csx;
   logic       host_rdx;
   word_t      host_rdata;
   logic       host_waitx;
   logic       irq_bank0;
   logic       irq_bank1;

   int          assert_errs = 0;
   int          data_errs = 0;
   int          timeout_errs = 0;
   int          fields_done = 0;      // odd fields sent
   logic        host_busy = 1'b0;     // strobes low
   logic        irq0_d = 1'b0;
   logic        irq1_d = 1'b0;
   int          irq0_rises = 0;
   int          irq1_rises = 0;
   int          px_y [32];            // pixel bytes of next field
   int          px_cb [32];
   int          px_cr [32];
   word_t       exp0 [32];            // expected bank contents
   word_t       exp1 [32];
   word_t       keep0;                // words past the field end
   word_t       keep1;
   word_t       forced_words [5] = '{16'h0000, 16'hffff, 16'h07e0, 16'hf800, 16'h001f};

   always #50 clk_llc = ~clk_llc;     // 100 ns

   frame_top u_frame_top (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .vref       (vref),
      .href       (href),
      .odd        (odd),
      .vid_data   (vid_data),
      .host_addr  (host_addr),
      .host_csx   (host_csx),
      .host_rdx   (host_rdx),
      .host_rdata (host_rdata),
      .host_waitx (host_waitx),
      .irq_bank0  (irq_bank0),
      .irq_bank1  (irq_bank1)
   );

   //----------------------------------------------------------
   // reference model
   function automatic color_class_t class_of(input int y, input int cb, input int cr);
      if (y < `BLACK_MAX)
         return class_black;
      if (y > `WHITE_MIN)
         return class_white;
      if (cb * cb + cr * cr < `GREEN_CHROMA_MAX)
         return class_green;
      if (cb < `RED_CB_MAX && cr > `RED_CR_MIN)
         return class_red;
      if (cb > `BLUE_CB_MIN && cr < `BLUE_CR_MAX)
         return class_blue;
      return class_natural;
   endfunction

   // sum scaled by 256 -> 0..255
   function automatic logic [7:0] to_channel(input int s);
      if (s < 0)
         return 8'd0;
      if (s / 256 > 255)
         return 8'd255;
      return 8'(s / 256);
   endfunction

   function automatic word_t model_word(input int y, input int cb, input int cr);
      int         yt;
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      yt = int'(`COEF_Y) * (y - `Y_OFFSET);
      r  = to_channel(yt + int'(`COEF_CR_R) * (cr - `C_OFFSET));
      g  = to_channel(yt - int'(`COEF_CR_G) * (cr - `C_OFFSET)
                         - int'(`COEF_CB_G) * (cb - `C_OFFSET));
      b  = to_channel(yt + int'(`COEF_CB_B) * (cb - `C_OFFSET));
      case (class_of(y, cb, cr))
         class_black: return 16'h0000;
         class_white: return 16'hffff;
         class_green: return 16'h07e0;
         class_red:   return 16'hf800;
         class_blue:  return 16'h001f;
         default:     return {r[7:3], g[7:2], b[7:3]};
      endcase
   endfunction

   //----------------------------------------------------------
   // stimulus tasks
   task automatic fill_forced();
      int n;
      for (n = 0; n < 32; n++)
      begin
         case (n % 5)
            0: begin px_y[n] = 30;  px_cb[n] = 128; px_cr[n] = 128; end   // black
            1: begin px_y[n] = 220; px_cb[n] = 128; px_cr[n] = 128; end   // white
            2: begin px_y[n] = 120; px_cb[n] = 80;  px_cr[n] = 80;  end   // low chroma
            3: begin px_y[n] = 120; px_cb[n] = 100; px_cr[n] = 200; end   // red
            default: begin px_y[n] = 120; px_cb[n] = 200; px_cr[n] = 100; end
         endcase
         exp0[n] = forced_words[n % 5];
      end
   endtask

   // y 60..190, cb cr 130..160, outside every class
   task automatic fill_natural();
      int n;
      for (n = 0; n < 32; n++)
      begin
         px_y[n]  = 60 + int'($urandom % 131);
         px_cb[n] = 130 + int'($urandom % 31);
         px_cr[n] = 130 + int'($urandom % 31);
         exp1[n]  = model_word(px_y[n], px_cb[n], px_cr[n]);
      end
   endtask

   // 8 lines of 64 bytes, even lines carry the pixels
   task automatic drive_field(input logic odd_lvl);
      int         ln;
      int         b;
      int         n;
      logic [7:0] v;
      @(posedge clk_llc);
      vref <= 1'b1;
      odd  <= odd_lvl;
      repeat (4) @(posedge clk_llc);
      for (ln = 0; ln < 8; ln++)
      begin
         for (b = 0; b < 64; b++)
         begin
            n = (ln / 2) * 8 + b / 8;
            case (b % 8)
               0:       v = 8'(px_cb[n]);
               1, 3:    v = 8'(px_y[n]);
               2:       v = 8'(px_cr[n]);
               default: v = 8'($urandom);      // second group, unused
            endcase
            if (ln % 2 == 1)
               v = 8'($urandom);               // dropped line
            @(posedge clk_llc);
            href     <= 1'b1;
            vid_data <= v;
         end
         @(posedge clk_llc);
         href     <= 1'b0;
         vid_data <= 8'h10;
         repeat (12) @(posedge clk_llc);       // line blanking
      end
      @(posedge clk_llc);
      vref <= 1'b0;
      odd  <= 1'b0;
      if (odd_lvl)
         fields_done <= fields_done + 1;
      repeat (8) @(posedge clk_llc);
   endtask

   // pulse is over before the field tail ends, so watch the rise count
   task automatic wait_irq(input logic which);
      int cnt;
      cnt = 0;
      while ((which ? irq1_rises : irq0_rises) == 0 && cnt < 30)
      begin
         @(posedge clk_llc);
         cnt++;
      end
      if ((which ? irq1_rises : irq0_rises) == 0)
      begin
         timeout_errs++;
         $display("timeout: no interrupt for bank %0d after the field ended", which);
      end
      repeat (4) @(posedge clk_llc);
   endtask

   // strobe read, hold until wait drops and returns high
   task automatic host_read(input word_addr_t addr, output word_t data, output logic ok);
      int cnt;
      ok = 1'b1;
      @(posedge clk_llc);
      host_addr <= addr;
      host_csx  <= 1'b0;
      host_rdx  <= 1'b0;
      host_busy <= 1'b1;
      @(posedge clk_llc);
      cnt = 0;
      while (host_waitx && cnt < 10)
      begin
         @(posedge clk_llc);
         cnt++;
      end
      if (host_waitx)
      begin
         ok = 1'b0;
         timeout_errs++;
         $display("timeout: wait never went low for host read at %h", addr);
      end
      cnt = 0;
      while (!host_waitx && cnt < 10)
      begin
         @(posedge clk_llc);
         cnt++;
      end
      if (!host_waitx)
      begin
         ok = 1'b0;
         timeout_errs++;
         $display("timeout: wait stuck low for host read at %h", addr);
      end
      data = host_rdata;
      host_csx  <= 1'b1;
      host_rdx  <= 1'b1;
      host_busy <= 1'b0;
      @(posedge clk_llc);                      // bus turnaround
   endtask

   task automatic check_word(input string name, input word_addr_t addr, input word_t exp);
      word_t got;
      logic  ok;
      host_read(addr, got, ok);
      if (ok)
         assert (got === exp)
         else
         begin
            data_errs++;
            $display("CHECK FAILED %s addr %h expected %h actual %h", name, addr, exp, got);
         end
   endtask

   //----------------------------------------------------------
   // checking assertions
   a_quiet_before_field: assert property (@(posedge clk_llc) disable iff (!resetx)
      (fields_done == 0) |-> (!irq_bank0 && !irq_bank1))
      else
      begin
         assert_errs++;
         $display("interrupt raised before the first field ended");
      end
   a_wait_high: assert property (@(posedge clk_llc) disable iff (!resetx)
      !host_busy |-> host_waitx)
      else
      begin
         assert_errs++;
         $display("host wait low with no host read active");
      end
   a_irq0_len: assert property (@(posedge clk_llc) disable iff (!resetx)
      $rose(irq_bank0) |-> ##1 irq_bank0 ##1 !irq_bank0)
      else
      begin
         assert_errs++;
         $display("bank 0 interrupt pulse not two cycles long");
      end
   a_irq1_len: assert property (@(posedge clk_llc) disable iff (!resetx)
      $rose(irq_bank1) |-> ##1 irq_bank1 ##1 !irq_bank1)
      else
      begin
         assert_errs++;
         $display("bank 1 interrupt pulse not two cycles long");
      end
   a_irq0_first: assert property (@(posedge clk_llc) disable iff (!resetx)
      $rose(irq_bank0) |-> (fields_done == 1))
      else
      begin
         assert_errs++;
         $display("bank 0 interrupt not at the end of the first field");
      end
   a_irq1_second: assert property (@(posedge clk_llc) disable iff (!resetx)
      $rose(irq_bank1) |-> (fields_done == 2))
      else
      begin
         assert_errs++;
         $display("bank 1 interrupt not at the end of the second field");
      end

   always @(posedge clk_llc)
   begin
      irq0_d <= irq_bank0;
      irq1_d <= irq_bank1;
      if (irq_bank0 && !irq0_d)
         irq0_rises <= irq0_rises + 1;
      if (irq_bank1 && !irq1_d)
         irq1_rises <= irq1_rises + 1;
   end

   //----------------------------------------------------------
   // main sequence
   initial
   begin
      int    n;
      logic  ok;
      void'($urandom(32'h66d2_1a8e));
      resetx    = 1'b0;
      vref      = 1'b0;
      href      = 1'b0;
      odd       = 1'b0;
      vid_data  = 8'h00;
      host_addr = '0;
      host_csx  = 1'b1;
      host_rdx  = 1'b1;
      repeat (16) @(posedge clk_llc);
      resetx <= 1'b1;
      repeat (4)
      begin
         @(posedge clk_llc);
         assert (host_waitx && !irq_bank0 && !irq_bank1)
         else
         begin
            assert_errs++;
            $display("outputs not idle after reset");
         end
      end

      // first word past each field, never written
      host_read(word_addr_t'(`BANK0_BASE + 32), keep0, ok);
      host_read(word_addr_t'(`BANK1_BASE + 32), keep1, ok);

      fill_forced();
      drive_field(1'b1);
      wait_irq(1'b0);
      for (n = 0; n < 32; n++)
         check_word("forced_classes", word_addr_t'(`BANK0_BASE + n), exp0[n]);
      check_word("bank0_end", word_addr_t'(`BANK0_BASE + 32), keep0);

      fill_natural();
      drive_field(1'b0);                       // even field, ignored
      if (irq0_rises != 1 || irq1_rises != 0)
      begin
         assert_errs++;
         $display("interrupt count wrong after the even field");
      end

      fork
         drive_field(1'b1);
         begin
            repeat (100) @(posedge clk_llc);   // into the kept lines
            for (n = 0; n < 32; n++)
               check_word("read_in_video", word_addr_t'(`BANK0_BASE + n), exp0[n]);
         end
      join
      wait_irq(1'b1);
      for (n = 0; n < 32; n++)
         check_word("natural_pixels", word_addr_t'(`BANK1_BASE + n), exp1[n]);
      check_word("bank1_end", word_addr_t'(`BANK1_BASE + 32), keep1);
      for (n = 0; n < 32; n++)
         check_word("bank0_kept", word_addr_t'(`BANK0_BASE + n), exp0[n]);
      check_word("bank0_end_kept", word_addr_t'(`BANK0_BASE + 32), keep0);

      if (irq0_rises != 1 || irq1_rises != 1)
      begin
         assert_errs++;
         $display("expected one interrupt per bank, saw %0d and %0d", irq0_rises, irq1_rises);
      end

      repeat (4) @(posedge clk_llc);
      $display("errors: assertion %0d, data %0d, timeout %0d",
               assert_errs, data_errs, timeout_errs);
      if (assert_errs + data_errs + timeout_errs == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- source/frame_top.sv
//----------------------------------------------------------
// frame grabber top: decoder timing, colour converter,
// memory arbiter and frame ram
//----------------------------------------------------------
module frame_top
   import video_pkg::*, bus_pkg::*;
(
   input  logic       clk_llc,
   input  logic       resetx,
   // video decoder
   input  logic       vref,
   input  logic       href,
   input  logic       odd,
   input  logic [7:0] vid_data,
   // host strobe bus
   input  word_addr_t host_addr,
   input  logic       host_csx,
   input  logic       host_rdx,
   output word_t      host_rdata,
   output logic       host_waitx,
   output logic       irq_bank0,
   output logic       irq_bank1
);

   byte_phase_t phase;

   pix_wr_if   pix ();
   mem_port_if mem ();

   video_timing u_timing (
      .clk_llc   (clk_llc),
      .resetx    (resetx),
      .vref      (vref),
      .href      (href),
      .odd       (odd),
      .phase     (phase),
      .pix       (pix.source),
      .irq_bank0 (irq_bank0),
      .irq_bank1 (irq_bank1)
   );

   ycbcr_to_rgb565 u_conv (
      .clk_llc  (clk_llc),
      .resetx   (resetx),
      .vid_data (vid_data),
      .phase    (phase),
      .pix      (pix.source)
   );

   mem_arbiter u_arb (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .pix        (pix.sink),
      .mem        (mem.master),
      .host_addr  (host_addr),
      .host_csx   (host_csx),
      .host_rdx   (host_rdx),
      .host_rdata (host_rdata),
      .host_waitx (host_waitx)
   );

   frame_ram u_ram (
      .clk_llc (clk_llc),
      .mem     (mem.slave)
   );

endmodule

//--- source/frame_ram.sv
//----------------------------------------------------------
// frame memory, 64K words, one port, registered read
//----------------------------------------------------------
`include "frame_consts.svh"

module frame_ram
   import bus_pkg::*;
(
   input  logic       clk_llc,
   mem_port_if.slave  mem
);

   localparam int DEPTH = 2 ** `FRAME_ADDR_W;

   word_t ram [DEPTH];     // two banks of 32K words

   always_ff @(posedge clk_llc)
   begin
      if (mem.wren)
         ram[mem.addr] <= mem.wdata;
      if (mem.rden)
         mem.q <= ram[mem.addr];     // valid next cycle
   end

endmodule

//--- source/mem_arbiter.sv
//----------------------------------------------------------
// frame memory arbiter: video writes against host reads,
// one pending pixel, host wait generation
//----------------------------------------------------------
`include "frame_consts.svh"

module mem_arbiter
   import bus_pkg::*;
(
   input  logic       clk_llc,
   input  logic       resetx,
   pix_wr_if.sink     pix,
   mem_port_if.master mem,
   input  word_addr_t host_addr,
   input  logic       host_csx,
   input  logic       host_rdx,
   output word_t      host_rdata,
   output logic       host_waitx
);

   arb_state_t state;
   arb_state_t state_next;
   logic       rd_req;       // host strobes both low
   logic       pend_vld;
   word_addr_t pend_addr;
   word_t      pend_data;

   assign rd_req = ~host_csx & ~host_rdx;

   //----------------------------------------------------------
   // pending pixel, one entry
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
         pend_vld <= 1'b0;
      else if (pix.wr)
         pend_vld <= 1'b1;
      else if (state == st_vwrite)
         pend_vld <= 1'b0;
   end

   always_ff @(posedge clk_llc)
   begin
      if (pix.wr)
      begin
         // bank bit picks the ram half
         pend_addr <= {pix.bank, pix.addr[`FRAME_ADDR_W-2:0]};
         pend_data <= pix.data;
      end
   end

   //----------------------------------------------------------
   // state machine
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
         state <= st_idle;
      else
         state <= state_next;
   end

   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:
            if (pend_vld)
               state_next = st_vwrite;       // video first
            else if (rd_req)
               state_next = st_rd_addr;
         st_vwrite:
            state_next = rd_req ? st_rd_addr : st_idle;
         st_rd_addr:
            state_next = st_rd_data;
         st_rd_data:
            state_next = st_rd_hold;
         st_rd_hold:
            if (host_rdx)
               state_next = st_idle;
         default:
            state_next = st_idle;
      endcase
   end

   assign mem.wren  = (state == st_vwrite);
   assign mem.rden  = (state == st_rd_addr);
   assign mem.addr  = (state == st_vwrite) ? pend_addr : host_addr;
   assign mem.wdata = pend_data;

   // low until host_rdata holds the word
   assign host_waitx = ~((state == st_rd_addr) | (state == st_rd_data) |
                         ((state == st_vwrite) & rd_req));

   always_ff @(posedge clk_llc)
   begin
      if (state == st_rd_data)
         host_rdata <= mem.q;
   end

   a_one_access: assert property (@(posedge clk_llc) disable iff (!resetx)
      !(mem.wren && mem.rden));
   // new pixel never lands on one still waiting
   a_idle_no_wait: assert property (@(posedge clk_llc) disable iff (!resetx)
      pix.wr |-> (!pend_vld || state == st_vwrite));
   // 2 wait cycles, 3 behind a pending pixel
   a_wait_bound: assert property (@(posedge clk_llc) disable iff (!resetx)
      $fell(host_waitx) |-> ##[1:3] host_waitx);

endmodule

//--- source/ycbcr_to_rgb565.sv
//----------------------------------------------------------
// ycbcr to rgb565: byte capture, three-stage conversion with
// colour class forcing, pixel write strobe
//----------------------------------------------------------
`include "frame_consts.svh"

module ycbcr_to_rgb565
   import video_pkg::*;
(
   input  logic        clk_llc,
   input  logic        resetx,
   input  logic [7:0]  vid_data,
   input  byte_phase_t phase,
   pix_wr_if.source    pix
);

   logic [7:0]         cb_q;            // captured bytes
   logic [7:0]         y_q;
   logic [7:0]         cr_q;
   logic signed [8:0]  y_off;
   logic signed [8:0]  cb_off;
   logic signed [8:0]  cr_off;
   logic               cap_vld;         // cr just captured
   logic               prod_vld;
   logic               sum_vld;
   logic signed [19:0] prod_y;          // stage 1 products
   logic signed [19:0] prod_cr_r;
   logic signed [19:0] prod_cr_g;
   logic signed [19:0] prod_cb_g;
   logic signed [19:0] prod_cb_b;
   logic [15:0]        cb_sq;
   logic [15:0]        cr_sq;
   logic [7:0]         y1;
   logic [7:0]         cb1;
   logic [7:0]         cr1;
   logic signed [20:0] r_sum;           // stage 2, scaled by 256
   logic signed [20:0] g_sum;
   logic signed [20:0] b_sum;
   color_class_t       cls_next;
   color_class_t       cls_q;
   logic [7:0]         r8;
   logic [7:0]         g8;
   logic [7:0]         b8;

   function automatic logic signed [19:0] mul_coef(input logic [9:0] coef,
                                                   input logic signed [8:0] v);
      return $signed({1'b0, coef}) * v;
   endfunction

   // negative -> 0, above 255 -> 255, else drop fraction
   function automatic logic [7:0] clamp8(input logic signed [20:0] s);
      if (s[20])
         return 8'd0;
      else if (|s[19:16])
         return 8'hff;
      return s[15:8];
   endfunction

   always_ff @(posedge clk_llc)
   begin
      case (phase)
         3'd0: cb_q <= vid_data;
         3'd1: y_q  <= vid_data;
         3'd2: cr_q <= vid_data;
         default: ;                     // second group dropped
      endcase
   end

   assign y_off  = 9'($signed({1'b0, y_q})  - `Y_OFFSET);
   assign cb_off = 9'($signed({1'b0, cb_q}) - `C_OFFSET);
   assign cr_off = 9'($signed({1'b0, cr_q}) - `C_OFFSET);

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         cap_vld  <= 1'b0;
         prod_vld <= 1'b0;
         sum_vld  <= 1'b0;
         pix.wr   <= 1'b0;
      end
      else
      begin
         cap_vld  <= (phase == 3'd2);
         prod_vld <= cap_vld;
         sum_vld  <= prod_vld;
         pix.wr   <= sum_vld;          // 3 cycles after cr sample
      end
   end

   //----------------------------------------------------------
   // stage 1, products and chroma squares
   always_ff @(posedge clk_llc)
   begin
      if (cap_vld)
      begin
         prod_y    <= mul_coef(`COEF_Y, y_off);
         prod_cr_r <= mul_coef(`COEF_CR_R, cr_off);
         prod_cr_g <= mul_coef(`COEF_CR_G, cr_off);
         prod_cb_g <= mul_coef(`COEF_CB_G, cb_off);
         prod_cb_b <= mul_coef(`COEF_CB_B, cb_off);
         cb_sq     <= cb_q * cb_q;
         cr_sq     <= cr_q * cr_q;
         y1        <= y_q;
         cb1       <= cb_q;
         cr1       <= cr_q;
      end
   end

   // classifier, first match wins
   always_comb
   begin
      if (y1 < `BLACK_MAX)
         cls_next = class_black;
      else if (y1 > `WHITE_MIN)
         cls_next = class_white;
      else if (cb_sq + cr_sq < `GREEN_CHROMA_MAX)
         cls_next = class_green;
      else if (cb1 < `RED_CB_MAX && cr1 > `RED_CR_MIN)
         cls_next = class_red;
      else if (cb1 > `BLUE_CB_MIN && cr1 < `BLUE_CR_MAX)
         cls_next = class_blue;
      else
         cls_next = class_natural;
   end

   //----------------------------------------------------------
   // stage 2, channel sums and class
   always_ff @(posedge clk_llc)
   begin
      if (prod_vld)
      begin
         r_sum <= prod_y + prod_cr_r;
         g_sum <= prod_y - prod_cr_g - prod_cb_g;
         b_sum <= prod_y + prod_cb_b;
         cls_q <= cls_next;
      end
   end

   assign r8 = clamp8(r_sum);
   assign g8 = clamp8(g_sum);
   assign b8 = clamp8(b_sum);

   // stage 3, forced colours or truncated 5-6-5
   always_ff @(posedge clk_llc)
   begin
      if (sum_vld)
      begin
         case (cls_q)
            class_black: pix.data <= 16'h0000;
            class_white: pix.data <= 16'hffff;
            class_green: pix.data <= 16'h07e0;
            class_red:   pix.data <= 16'hf800;
            class_blue:  pix.data <= 16'h001f;
            default:     pix.data <= '{red: r8[7:3], green: g8[7:2], blue: b8[7:3]};
         endcase
      end
   end

   // pixels are a block apart, never back to back
   a_wr_single: assert property (@(posedge clk_llc) disable iff (!resetx)
      pix.wr |=> !pix.wr);

endmodule

//--- source/video_timing.sv
//----------------------------------------------------------
// video timing: odd field and kept line detection, byte
// phase, frame address, bank flip and field interrupts
//----------------------------------------------------------
`include "frame_consts.svh"

module video_timing
   import video_pkg::*, bus_pkg::*;
(
   input  logic        clk_llc,
   input  logic        resetx,
   input  logic        vref,
   input  logic        href,
   input  logic        odd,
   output byte_phase_t phase,
   pix_wr_if.source    pix,
   output logic        irq_bank0,
   output logic        irq_bank1
);

   localparam int IRQ_CW = $clog2(`IRQ_LEN + 1);

   logic              odd_field;     // odd & vref
   logic              odd_field_d;
   logic              field_end;
   logic              href_d;
   logic              href_rise;
   logic              line_keep_q;
   logic              line_keep;     // current line kept
   logic              byte_en;
   logic              bank;
   logic [IRQ_CW-1:0] irq_cnt;
   word_addr_t        pix_ofs;       // pixels written this field

   assign odd_field = odd & vref;
   assign field_end = odd_field_d & ~odd_field;
   assign href_rise = href & ~href_d & odd_field;
   // toggle already seen on the rising edge itself
   assign line_keep = href_rise ? ~line_keep_q : line_keep_q;
   assign byte_en   = href & line_keep & odd_field;

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         href_d      <= 1'b0;
         odd_field_d <= 1'b0;
         line_keep_q <= 1'b0;
      end
      else
      begin
         href_d      <= href;
         odd_field_d <= odd_field;
         if (!odd_field)
            line_keep_q <= 1'b0;     // first line of next field kept
         else
            line_keep_q <= line_keep;
      end
   end

   //----------------------------------------------------------
   // byte phase and pixel address
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         phase   <= '0;
         pix_ofs <= '0;
      end
      else
      begin
         if (byte_en)
            phase <= phase + 3'd1;   // wraps 7 -> 0
         else
            phase <= '0;
         if (!odd_field)
            pix_ofs <= '0;
         else if (pix.wr)
            pix_ofs <= pix_ofs + 1'b1;
      end
   end

   assign pix.bank = bank;
   assign pix.addr = (bank ? `BANK1_BASE : `BANK0_BASE) + pix_ofs;

   //----------------------------------------------------------
   // bank flip and interrupt pulse at end of odd field
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         bank    <= 1'b0;
         irq_cnt <= '0;
      end
      else if (field_end)
      begin
         bank    <= ~bank;
         irq_cnt <= IRQ_CW'(`IRQ_LEN);
      end
      else if (irq_cnt != '0)
         irq_cnt <= irq_cnt - 1'b1;
   end

   // bank already flipped, so name the other one
   assign irq_bank0 = (irq_cnt != '0) &  bank;
   assign irq_bank1 = (irq_cnt != '0) & ~bank;

   // pixels from kept lines land before the field closes
   a_phase_in_line: assert property (@(posedge clk_llc) disable iff (!resetx)
      pix.wr |-> odd_field);

endmodule

//--- source/frame_ifs.sv
//----------------------------------------------------------
// frame grabber internal interfaces: pixel write path and
// frame memory port
//----------------------------------------------------------

//----------------------------------------------------------
// pixel write, timing side drives addr/bank and the
// converter drives wr/data
interface pix_wr_if
   import bus_pkg::*, video_pkg::*;
   ();

   logic       wr;      // one-cycle strobe
   word_addr_t addr;    // bank base plus pixel count
   rgb565_t    data;
   logic       bank;    // bank being filled

   modport source (output wr, addr, data, bank);
   modport sink   (input  wr, addr, data, bank);

endinterface

//----------------------------------------------------------
// single-port ram, q one cycle after rden
interface mem_port_if
   import bus_pkg::*;
   ();

   word_addr_t addr;
   word_t      wdata;
   logic       wren;
   logic       rden;
   word_t      q;

   modport master (output addr, wdata, wren, rden, input q);
   modport slave  (input  addr, wdata, wren, rden, output q);

endinterface

//--- source/bus_pkg.sv
//----------------------------------------------------------
// memory bus types: arbiter states, word address and data
//----------------------------------------------------------
`include "frame_consts.svh"

package bus_pkg;

   // frame memory arbiter
   typedef enum logic [2:0]
   {
      st_idle,          // waits for a pixel or a host read
      st_vwrite,        // one-cycle video write
      st_rd_addr,       // ram read issued
      st_rd_data,       // q latched to host_rdata
      st_rd_hold        // until host_rdx goes high
   } arb_state_t;

   typedef logic [`FRAME_ADDR_W-1:0] word_addr_t;
   typedef logic [`FRAME_DATA_W-1:0] word_t;

endpackage

//--- source/video_pkg.sv
//----------------------------------------------------------
// video types: colour class, rgb565 pixel, byte phase
//----------------------------------------------------------
package video_pkg;

   // colour classes, listed in classifier priority
   typedef enum logic [2:0]
   {
      class_black,
      class_white,
      class_green,
      class_red,
      class_blue,
      class_natural     // no forcing, converted value
   } color_class_t;

   // one frame memory word
   typedef struct packed
   {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } rgb565_t;

   // byte slot in a two-group block: cb y cr y cb y cr y
   // only slots 0..2 feed the converter
   typedef logic [2:0] byte_phase_t;

endpackage

//--- source/frame_consts.svh
//----------------------------------------------------------
// frame grabber constants: memory widths, bank bases,
// colour conversion coefficients and class thresholds
//----------------------------------------------------------
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

//----------------------------------------------------------
// frame memory
`define FRAME_ADDR_W      16
`define FRAME_DATA_W      16
`define BANK0_BASE        16'h0000   // first odd field
`define BANK1_BASE        16'h8000   // upper half of the ram

//----------------------------------------------------------
// ycbcr to rgb, unsigned 2.8 fixed point
`define COEF_Y            10'd298    // 1.164
`define COEF_CR_R         10'd409    // 1.596
`define COEF_CR_G         10'd208    // 0.813
`define COEF_CB_G         10'd100    // 0.392
`define COEF_CB_B         10'd516    // 2.017
`define Y_OFFSET          16         // 8-bit scale
`define C_OFFSET          128

//----------------------------------------------------------
// colour classes, raw 8-bit y cb cr
`define BLACK_MAX         60
`define WHITE_MIN         190
`define GREEN_CHROMA_MAX  22000      // on cb*cb + cr*cr
`define RED_CB_MAX        130
`define RED_CR_MIN        160
`define BLUE_CB_MIN       160
`define BLUE_CR_MAX       130

// field interrupt pulse, in clk_llc cycles
`define IRQ_LEN           2

`endif
